/* design/prof_pkg.sv */
package prof_pkg;

   //////////////////////////////
   // sizes
   //////////////////////////////

   localparam int CNT_W   = 32;
   localparam int NUM_CAT = 8;
   // total counter sits at id 0
   localparam int NUM_CNT = NUM_CAT + 1;
   localparam int ID_W    = 4;
   localparam int COORD_W = 4;

   //////////////////////////////
   // types
   //////////////////////////////

   // per-cycle flags from the tile
   typedef struct packed {
      logic reset_prof;
      logic finish_prof;
      logic dmem_stall;
      logic dx_stall;
      logic bt_stall;
      logic res_acq_stall;
      logic credit_full;
      logic out_fifo_full;
      logic in_fifo_full;
   } prof_trig_s;

   // highest priority first
   typedef enum logic [2:0] {
      CAT_DMEM     = 3'd0,
      CAT_DX       = 3'd1,
      CAT_BT       = 3'd2,
      CAT_RES_ACQ  = 3'd3,
      CAT_CREDIT   = 3'd4,
      CAT_OUT_FIFO = 3'd5,
      CAT_IN_FIFO  = 3'd6,
      CAT_BUSY     = 3'd7
   } prof_cat_e;

   typedef struct packed {
      logic      count_v;
      logic      clear;
      prof_cat_e cat;
   } prof_class_s;

   // one dumped counter
   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
      logic [ID_W-1:0]    id;
      logic [CNT_W-1:0]   count;
   } prof_record_s;

endpackage

/* design/prof_event_decode.sv */
`timescale 1ns/1ps

module prof_event_decode
   import prof_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  prof_trig_s  prof_i,
   output prof_class_s class_o,
   output logic        stop_o
);

   prof_trig_s trig_r;
   logic       running_r;
   logic       start;
   logic       finish;
   prof_cat_e  cat;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         trig_r    <= '0;
         running_r <= 1'b0;
      end
      else
      begin
         trig_r <= prof_i;
         if (start)
         begin
            running_r <= 1'b1;
         end
         else if (finish)
         begin
            running_r <= 1'b0;
         end
      end
   end

   // start beats finish, finish only counts while running
   assign start  = trig_r.reset_prof;
   assign finish = trig_r.finish_prof & running_r & ~start;

   //////////////////////////////
   // priority pick
   //////////////////////////////

   always_comb
   begin
      if (trig_r.dmem_stall)
         cat = CAT_DMEM;
      else if (trig_r.dx_stall)
         cat = CAT_DX;
      else if (trig_r.bt_stall)
         cat = CAT_BT;
      else if (trig_r.res_acq_stall)
         cat = CAT_RES_ACQ;
      else if (trig_r.credit_full)
         cat = CAT_CREDIT;
      else if (trig_r.out_fifo_full)
         cat = CAT_OUT_FIFO;
      else if (trig_r.in_fifo_full)
         cat = CAT_IN_FIFO;
      else
         cat = CAT_BUSY;
   end

   // start and finish cycles themselves are not counted
   assign class_o.count_v = running_r & ~start & ~finish;
   assign class_o.clear   = start;
   assign class_o.cat     = cat;
   assign stop_o          = finish;

endmodule

/* design/prof_counter_bank.sv */
`timescale 1ns/1ps

module prof_counter_bank
   import prof_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  prof_class_s                    class_i,
   output logic [NUM_CNT-1:0][CNT_W-1:0]  counts_o
);

   logic [NUM_CNT-1:0][CNT_W-1:0] cnt_r;
   logic [NUM_CNT-1:0]            inc;

   //////////////////////////////
   // increment select
   //////////////////////////////

   always_comb
   begin
      inc = '0;
      if (class_i.count_v)
      begin
         // slot 0 is the total, categories start at 1
         inc[0] = 1'b1;
         inc[int'(class_i.cat) + 1] = 1'b1;
      end
   end

   //////////////////////////////
   // counters
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         cnt_r <= '0;
      end
      else if (class_i.clear)
      begin
         cnt_r <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_CNT; i++)
         begin
            // wraps at CNT_W bits
            if (inc[i])
            begin
               cnt_r[i] <= cnt_r[i] + CNT_W'(1);
            end
         end
      end
   end

   assign counts_o = cnt_r;

endmodule

/* design/prof_report.sv */
`timescale 1ns/1ps

module prof_report
   import prof_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n_i,
   input  logic                          stop_i,
   input  logic [NUM_CNT-1:0][CNT_W-1:0] counts_i,
   input  logic [COORD_W-1:0]            x_id_i,
   input  logic [COORD_W-1:0]            y_id_i,
   output logic                          record_v_o,
   output prof_record_s                  record_o,
   output logic                          done_o
);

   logic [NUM_CNT-1:0][CNT_W-1:0] snap_r;
   logic                          stop_r;
   logic                          busy_r;
   logic [ID_W-1:0]               idx_r;
   logic                          done_r;
   logic                          last;

   assign last = (idx_r == ID_W'(NUM_CNT - 1));

   //////////////////////////////
   // sequencer
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         stop_r <= 1'b0;
         busy_r <= 1'b0;
         idx_r  <= '0;
         done_r <= 1'b0;
      end
      else
      begin
         stop_r <= stop_i;
         done_r <= busy_r & last & ~stop_r;
         if (stop_r)
         begin
            // a fresh snapshot restarts the dump
            busy_r <= 1'b1;
            idx_r  <= '0;
         end
         else if (busy_r)
         begin
            if (last)
            begin
               busy_r <= 1'b0;
               idx_r  <= '0;
            end
            else
            begin
               idx_r <= idx_r + ID_W'(1);
            end
         end
      end
   end

   // one cycle after stop, so the last count has landed
   always_ff @(posedge clk)
   begin
      if (stop_r)
      begin
         snap_r <= counts_i;
      end
   end

   //////////////////////////////
   // record out
   //////////////////////////////

   assign record_v_o     = busy_r;
   assign record_o.x     = x_id_i;
   assign record_o.y     = y_id_i;
   assign record_o.id    = idx_r;
   assign record_o.count = snap_r[idx_r];
   assign done_o         = done_r;

endmodule

/* design/tile_profiler.sv */
`timescale 1ns/1ps

module tile_profiler
   import prof_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n_i,
   input  prof_trig_s         prof_i,
   input  logic [COORD_W-1:0] x_id_i,
   input  logic [COORD_W-1:0] y_id_i,
   output logic               record_v_o,
   output prof_record_s       record_o,
   output logic               done_o
);

   prof_class_s                   class_w;
   logic                          stop_w;
   logic [NUM_CNT-1:0][CNT_W-1:0] counts_w;

   // decode
   prof_event_decode u_decode (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .prof_i  (prof_i),
      .class_o (class_w),
      .stop_o  (stop_w)
   );

   // count
   prof_counter_bank u_counter_bank (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .class_i  (class_w),
      .counts_o (counts_w)
   );

   // dump
   prof_report u_report (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .stop_i     (stop_w),
      .counts_i   (counts_w),
      .x_id_i     (x_id_i),
      .y_id_i     (y_id_i),
      .record_v_o (record_v_o),
      .record_o   (record_o),
      .done_o     (done_o)
   );

endmodule

/* verification/tile_profiler_props.sv */
`timescale 1ns/1ps

module tile_profiler_props
   import prof_pkg::*;
(
   input logic clk,
   input logic rst_n_i,
   input logic record_v_o,
   input logic done_o
);

   int unsigned run_len_r;
   logic        seen_rst_r;

   // length of the current record burst
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         run_len_r <= 0;
      else if (record_v_o)
         run_len_r <= run_len_r + 1;
      else
         run_len_r <= 0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         seen_rst_r <= 1'b1;
   end

   burst_not_long: assert property (@(posedge clk) disable iff (!rst_n_i)
      record_v_o |-> run_len_r < NUM_CNT)
      else $error("record burst longer than %0d cycles", NUM_CNT);

   burst_full: assert property (@(posedge clk) disable iff (!rst_n_i)
      $fell(record_v_o) |-> run_len_r == NUM_CNT)
      else $error("record burst shorter than %0d cycles", NUM_CNT);

   done_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
      $fell(record_v_o) |-> done_o && !$past(done_o))
      else $error("done_o missing after the last record");

   done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      done_o |=> !done_o)
      else $error("done_o longer than one cycle");

   quiet_in_reset: assert property (@(posedge clk)
      (!rst_n_i && seen_rst_r) |-> (!record_v_o && !done_o))
      else $error("report output high during reset");

endmodule

bind prof_report tile_profiler_props u_props (
   .clk        (clk),
   .rst_n_i    (rst_n_i),
   .record_v_o (record_v_o),
   .done_o     (done_o)
);

/* verification/tile_profiler_tb.sv */
`timescale 1ns/1ps

module tile_profiler_tb
   import prof_pkg::*;
();

   // the five tests take about 700 cycles
   localparam int MAX_CYCLES = 3000;
   localparam logic [COORD_W-1:0] TILE_X = 4'h5;
   localparam logic [COORD_W-1:0] TILE_Y = 4'hA;

   logic               clk;
   logic               rst_n_i;
   prof_trig_s         prof_i;
   logic [COORD_W-1:0] x_id_i;
   logic [COORD_W-1:0] y_id_i;
   logic               record_v_o;
   prof_record_s       record_o;
   logic               done_o;

   // reference model
   logic [CNT_W-1:0] exp_cnt [NUM_CNT];
   logic             model_run;
   logic [31:0]      lfsr_q;
   int unsigned      cycles = 0;
   int               errors = 0;

   // counts of the last dump
   logic [CNT_W-1:0] got_cnt [NUM_CNT];

   tile_profiler u_tile_profiler (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .prof_i     (prof_i),
      .x_id_i     (x_id_i),
      .y_id_i     (y_id_i),
      .record_v_o (record_v_o),
      .record_o   (record_o),
      .done_o     (done_o)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: the tests did not end within %0d cycles", cycles);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want)
      begin
         errors++;
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, want);
         $display("Verification failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // stall bits run dmem first, in struct order
   function automatic int expected_category(input logic [6:0] st);
      int cat;
      cat = NUM_CAT - 1;
      for (int k = NUM_CAT - 2; k >= 0; k--)
      begin
         if (st[6 - k])
            cat = k;
      end
      return cat;
   endfunction

   task automatic drive_cycles(input logic [6:0] st, input int n);
      int cat;
      repeat (n)
      begin
         @(posedge clk);
         prof_i <= {2'b00, st};
         if (model_run)
         begin
            cat = expected_category(st);
            exp_cnt[0]       = exp_cnt[0] + CNT_W'(1);
            exp_cnt[cat + 1] = exp_cnt[cat + 1] + CNT_W'(1);
         end
      end
   endtask

   task automatic start_run();
      @(posedge clk);
      prof_i <= '{reset_prof: 1'b1, default: 1'b0};
      exp_cnt = '{default: '0};
      model_run = 1'b1;
   endtask

   task automatic finish_run();
      @(posedge clk);
      prof_i <= '{finish_prof: 1'b1, default: 1'b0};
      model_run = 1'b0;
      @(posedge clk);
      prof_i <= '0;
   endtask

   task automatic collect_records();
      int lat;
      lat = 1;
      @(negedge clk);
      while (!record_v_o)
      begin
         lat++;
         @(negedge clk);
      end
      // cycles from the edge that samples finish
      check_value("first record latency", 64'(lat), 64'd3);
      for (int i = 0; i < NUM_CNT; i++)
      begin
         check_value("record_v_o", 64'(record_v_o), 64'd1);
         check_value("record_o.id", 64'(record_o.id), 64'(i));
         check_value("record_o.x", 64'(record_o.x), 64'(TILE_X));
         check_value("record_o.y", 64'(record_o.y), 64'(TILE_Y));
         check_value("record_o.count", 64'(record_o.count), 64'(exp_cnt[i]));
         got_cnt[i] = record_o.count;
         @(negedge clk);
      end
      check_value("record_v_o", 64'(record_v_o), 64'd0);
      check_value("done_o", 64'(done_o), 64'd1);
   endtask

   task automatic expect_no_records(input int n);
      repeat (n)
      begin
         @(negedge clk);
         check_value("record_v_o", 64'(record_v_o), 64'd0);
      end
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////

   task automatic test_idle();
      drive_cycles(7'h7f, 6);
      start_run();
      finish_run();
      collect_records();
      // idle flags after a dump
      drive_cycles(7'h15, 6);
      finish_run();
      expect_no_records(8);
   endtask

   task automatic test_single();
      logic [6:0] st;
      for (int k = 0; k < NUM_CAT; k++)
      begin
         st = (k < NUM_CAT - 1) ? 7'(7'h40 >> k) : 7'h00;
         start_run();
         drive_cycles(st, 10 + 3 * k);
         finish_run();
         collect_records();
      end
   endtask

   task automatic test_priority();
      start_run();
      drive_cycles(7'b1100000, 4);
      drive_cycles(7'b0010011, 5);
      drive_cycles(7'b0001101, 6);
      drive_cycles(7'b0000011, 7);
      drive_cycles(7'b0111111, 3);
      finish_run();
      collect_records();
   endtask

   task automatic test_random();
      logic [6:0]       st;
      logic [CNT_W-1:0] sum;
      start_run();
      repeat (200)
      begin
         for (int k = 0; k < 7; k++)
         begin
            lfsr_q = lfsr_step(lfsr_q);
            st[k]  = lfsr_q[0];
         end
         drive_cycles(st, 1);
      end
      finish_run();
      collect_records();
      // dumped total against its categories and the run length
      sum = '0;
      for (int i = 1; i < NUM_CNT; i++)
         sum = sum + got_cnt[i];
      check_value("record_o.count sum", 64'(sum), 64'(got_cnt[0]));
      check_value("record_o.count total", 64'(got_cnt[0]), 64'd200);
   endtask

   task automatic test_restart();
      start_run();
      drive_cycles(7'h40, 12);
      drive_cycles(7'h01, 5);
      // second start drops everything above
      start_run();
      drive_cycles(7'h08, 9);
      finish_run();
      collect_records();
      finish_run();
      expect_no_records(15);
   endtask

   initial
   begin
      rst_n_i   = 1'b0;
      prof_i    = '0;
      x_id_i    = TILE_X;
      y_id_i    = TILE_Y;
      lfsr_q    = 32'h36f4ba1f;
      model_run = 1'b0;
      exp_cnt   = '{default: '0};
      repeat (10) @(posedge clk);
      rst_n_i <= 1'b1;
      test_idle();
      test_single();
      test_priority();
      test_random();
      test_restart();
      if (errors == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* flist.f */
design/prof_pkg.sv
design/prof_event_decode.sv
design/prof_counter_bank.sv
design/prof_report.sv
design/tile_profiler.sv
verification/tile_profiler_props.sv
verification/tile_profiler_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tile_profiler_tb \
		-f flist.f -o tile_profiler_sim
	./obj_dir/tile_profiler_sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "test: FAIL"; exit 1; fi
	@if ! grep -q "Verification passed" sim.log; then \
		echo "test: FAIL, no result in sim.log"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf obj_dir sim.log
